// File: flist.f
miriscv_pkg.sv
miriscv_alu.sv
miriscv_decoder.sv
miriscv_rf.sv
miriscv_csr.sv
miriscv_lsu.sv
miriscv_core.sv
miriscv_core_assertions.sv
tb_miriscv_core.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_miriscv_core -o sim_tb
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  exit 1
fi

if echo "$out" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1

// File: tb_miriscv_core.sv
`timescale 1ns/1ps

module tb_miriscv_core import miriscv_pkg::*; ();

  localparam int          CLK_PERIOD = 100;
  localparam logic [31:0] HANDLER    = 32'h380; // Trap handler sits above the main program
  localparam logic [31:0] MIE_VALUE  = 32'h5A;
  localparam alu_op_e R_OPS [10] = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
                                     ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND};
  localparam alu_op_e I_OPS [9] = '{ALU_ADD, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR,
                                    ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA};
  localparam alu_op_e BR_OPS [6] = '{ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};
  localparam logic [2:0] BR_F3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic [31:0] instr_rdata_i;
  logic [31:0] instr_addr_o;
  logic [31:0] data_rdata_i;
  logic        data_req_o;
  logic        data_we_o;
  logic [3:0]  data_be_o;
  logic [31:0] data_addr_o;
  logic [31:0] data_wdata_o;
  logic        int_i;
  logic [31:0] mcause_i;
  logic        int_rst_o;
  logic [31:0] mie_o;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] shadow [256]; // Planned contents of the data memory
  logic [31:0] exp_addr_q [$];
  logic [3:0]  exp_be_q [$];
  logic [31:0] exp_data_q [$];
  logic [31:0] rng_state = 32'd45;
  logic [31:0] int_pc, end_pc, int_cause, mem_pc;
  int          pc_w, res_ptr, mem_cnt;
  int          prog_len = 0;
  bit          seen_store = 1'b0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  miriscv_core #(.BOOT_ADDR(32'h0)) i_miriscv_core (.*);

  assign instr_rdata_i = imem[instr_addr_o[9:2]]; // Combinational instruction fetch

  task automatic stop_with(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      stop_with($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_be(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp)
      stop_with($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      stop_with($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

  function automatic logic [31:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Expected ALU result where compares give the branch condition in bit 0
  function automatic logic [31:0] alu_ref(input alu_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_SLL:  return a << sh;
      ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: return {31'b0, a < b};
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return $unsigned($signed(a) >>> sh);
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_EQ:   return {31'b0, a == b};
      ALU_NE:   return {31'b0, a != b};
      ALU_LT:   return {31'b0, $signed(a) < $signed(b)};
      ALU_GE:   return {31'b0, $signed(a) >= $signed(b)};
      ALU_LTU:  return {31'b0, a < b};
      ALU_GEU:  return {31'b0, a >= b};
      default:  return 32'h0;
    endcase
  endfunction

  // Byte enables of an access and the value a load of that size returns
  function automatic logic [31:0] mem_ref(input mem_size_e size, input logic [1:0] off,
                                          input logic [31:0] word, output logic [3:0] be);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[off*8 +: 8];
    h = off[1] ? word[31:16] : word[15:0];
    case (size)
      MEM_BYTE: begin
        be = 4'b0001 << off;
        return {{24{b[7]}}, b};
      end
      MEM_BYTE_U: begin
        be = 4'b0001 << off;
        return {24'b0, b};
      end
      MEM_HALF: begin
        be = off[1] ? 4'b1100 : 4'b0011;
        return {{16{h[15]}}, h};
      end
      MEM_HALF_U: begin
        be = off[1] ? 4'b1100 : 4'b0011;
        return {16'b0, h};
      end
      default: begin
        be = 4'b1111;
        return word;
      end
    endcase
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[pc_w] = word;
    pc_w++;
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] val);
    logic [31:0] hi;
    hi = val + 32'h800; // ADDI sign-extends the low part
    emit(enc_u(hi[31:12], rd, OPC_LUI));
    emit(enc_i(val[11:0], rd, 3'b000, rd, OPC_OP_IMM));
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] data);
    exp_addr_q.push_back(addr);
    exp_be_q.push_back(be);
    exp_data_q.push_back(data);
  endtask

  task automatic store_result(input logic [4:0] rs, input logic [31:0] value);
    emit(enc_s(res_ptr[11:0], rs, 5'd0, 3'b010));
    expect_store(res_ptr, 4'hF, value);
    res_ptr += 4;
  endtask

  task automatic store_sized(input mem_size_e size, input logic [1:0] off,
                             input logic [4:0] rs, input logic [31:0] val);
    logic [3:0]  be;
    logic [31:0] wdata;
    void'(mem_ref(size, off, shadow[16], be));
    wdata = (size == MEM_BYTE) ? {4{val[7:0]}} : (size == MEM_HALF) ? {2{val[15:0]}} : val;
    for (int i = 0; i < 4; i++)
      if (be[i]) shadow[16][i*8 +: 8] = wdata[i*8 +: 8];
    emit(enc_s(12'h040 + off, rs, 5'd0, 3'(size)));
    expect_store(32'h40, be, wdata);
  endtask

  task automatic load_sized(input mem_size_e size, input logic [1:0] off);
    logic [3:0]  be;
    logic [31:0] val;
    val = mem_ref(size, off, shadow[16], be);
    emit(enc_i(12'h040 + off, 5'd0, 3'(size), 5'd6, OPC_LOAD));
    store_result(5'd6, val); // Loaded value goes back out as a word
  endtask

  // Marker x7 is stored on the fall-through path, x8 on the taken path
  task automatic branch_markers(input int k, input logic [4:0] rs1, input logic [4:0] rs2,
                                input logic [31:0] va, input logic [31:0] vb);
    logic [31:0] cmp;
    logic        taken;
    cmp   = alu_ref(BR_OPS[k], va, vb);
    taken = cmp[0];
    emit(enc_b(13'd12, rs2, rs1, BR_F3[k]));
    emit(enc_s(res_ptr[11:0], 5'd7, 5'd0, 3'b010));
    emit(enc_j(21'd8, 5'd0));
    emit(enc_s(res_ptr[11:0], 5'd8, 5'd0, 3'b010));
    expect_store(res_ptr, 4'hF, taken ? 32'h222 : 32'h111);
    res_ptr += 4;
  endtask

  task automatic build_program();
    logic [31:0] a, b, v4, v5, p, r_int;
    logic [11:0] imm;
    alu_op_e     op;
    pc_w    = 0;
    res_ptr = 32'h100;
    emit(enc_i(12'h111, 5'd0, 3'b000, 5'd7, OPC_OP_IMM));
    emit(enc_i(12'h222, 5'd0, 3'b000, 5'd8, OPC_OP_IMM));
    foreach (R_OPS[k]) begin
      op = R_OPS[k];
      a  = xorshift();
      b  = xorshift();
      load_const(5'd1, a);
      load_const(5'd2, b);
      emit(enc_r(op[3] ? 7'h20 : 7'h00, 5'd2, 5'd1, op[2:0], 5'd3, OPC_OP));
      store_result(5'd3, alu_ref(op, a, b));
    end
    foreach (I_OPS[k]) begin
      op  = I_OPS[k];
      a   = xorshift();
      b   = xorshift();
      imm = b[11:0];
      if (op == ALU_SLL || op == ALU_SRL)
        imm = {7'h00, b[4:0]};
      else if (op == ALU_SRA)
        imm = {7'h20, b[4:0]};
      load_const(5'd1, a);
      emit(enc_i(imm, 5'd1, op[2:0], 5'd3, OPC_OP_IMM));
      store_result(5'd3, alu_ref(op, a, {{20{imm[11]}}, imm}));
    end
    // Every store size and offset, then every load of the resulting word
    v4 = xorshift();
    v5 = xorshift();
    load_const(5'd4, v4);
    load_const(5'd5, v5);
    store_sized(MEM_WORD, 2'd0, 5'd4, v4);
    for (int off = 0; off < 4; off++)
      store_sized(MEM_BYTE, 2'(off), off[0] ? 5'd5 : 5'd4, off[0] ? v5 : v4);
    store_sized(MEM_HALF, 2'd0, 5'd5, v5);
    store_sized(MEM_HALF, 2'd2, 5'd4, v4);
    load_sized(MEM_WORD, 2'd0);
    for (int off = 0; off < 4; off += 2) begin
      load_sized(MEM_HALF, 2'(off));
      load_sized(MEM_HALF_U, 2'(off));
    end
    for (int off = 0; off < 4; off++) begin
      load_sized(MEM_BYTE, 2'(off));
      load_sized(MEM_BYTE_U, 2'(off));
    end
    a = xorshift();
    emit(enc_i(a[11:0], 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
    branch_markers(0, 5'd1, 5'd1, {{20{a[11]}}, a[11:0]}, {{20{a[11]}}, a[11:0]});
    branch_markers(1, 5'd1, 5'd1, {{20{a[11]}}, a[11:0]}, {{20{a[11]}}, a[11:0]});
    a = xorshift();
    a = {21'h1FFFFF, a[10:0]}; // Negative, so signed and unsigned orders differ
    b = xorshift();
    b = {21'h0, b[10:0]};
    emit(enc_i(a[11:0], 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
    emit(enc_i(b[11:0], 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
    for (int k = 0; k < 6; k++)
      branch_markers(k, 5'd1, 5'd2, a, b);
    for (int k = 0; k < 6; k++)
      branch_markers(k, 5'd2, 5'd1, b, a);
    p = pc_w * 4;
    emit(enc_j(21'd8, 5'd9));
    emit(enc_s(res_ptr[11:0], 5'd7, 5'd0, 3'b010));
    store_result(5'd9, p + 4);
    p = pc_w * 4;
    emit(enc_i(p[11:0] + 12'd13, 5'd0, 3'b000, 5'd10, OPC_OP_IMM)); // Odd target tests bit 0
    emit(enc_i(12'd0, 5'd10, 3'b000, 5'd11, OPC_JALR));
    emit(enc_s(res_ptr[11:0], 5'd7, 5'd0, 3'b010));
    store_result(5'd11, p + 8);
    emit(enc_i(HANDLER[11:0], 5'd0, 3'b000, 5'd12, OPC_OP_IMM));
    emit(enc_i(CSR_MTVEC, 5'd12, 3'b001, 5'd0, OPC_SYSTEM));
    emit(enc_i(MIE_VALUE[11:0], 5'd0, 3'b000, 5'd13, OPC_OP_IMM));
    emit(enc_i(CSR_MIE, 5'd13, 3'b001, 5'd0, OPC_SYSTEM));
    int_pc = pc_w * 4;
    r_int  = res_ptr;
    res_ptr += 4;
    emit(enc_i(12'd1, 5'd14, 3'b000, 5'd14, OPC_OP_IMM)); // Interrupted here, runs once after MRET
    emit(enc_s(r_int[11:0], 5'd14, 5'd0, 3'b010));
    end_pc = pc_w * 4;
    emit(enc_j(21'd0, 5'd0));
    prog_len  = pc_w;
    int_cause = xorshift();
    pc_w      = HANDLER / 4;
    emit(enc_i(CSR_MCAUSE, 5'd0, 3'b010, 5'd15, OPC_SYSTEM));
    store_result(5'd15, int_cause);
    emit(enc_i(CSR_MEPC, 5'd0, 3'b010, 5'd16, OPC_SYSTEM));
    store_result(5'd16, int_pc);
    emit(32'h3020_0073);
    expect_store(r_int, 4'hF, 32'd1);
  endtask

  task automatic wait_pc(input logic [31:0] target);
    while (instr_addr_o !== target)
      @(negedge clk_i);
  endtask

  // The data memory and the store checker sample the DUT at the falling edge
  always @(negedge clk_i) begin
    if (rst_n_i === 1'b0) begin
      if (mem_cnt == 1) begin
        if (data_req_o)
          stop_with("data_req_o stayed high in the second cycle of an access");
        check_addr("instr_addr_o", instr_addr_o, mem_pc); // PC held for one extra cycle
        mem_cnt = 2;
      end else begin
        if (mem_cnt == 2) begin
          check_addr("instr_addr_o", instr_addr_o, mem_pc + 4);
          mem_cnt = 0;
        end
        if (data_req_o) begin
          mem_pc  = instr_addr_o;
          mem_cnt = 1;
          if (data_we_o) begin
            if (exp_addr_q.size() == 0)
              stop_with($sformatf("unexpected store to %h", data_addr_o));
            seen_store = 1'b1;
            check_addr("data_addr_o", data_addr_o, exp_addr_q.pop_front());
            check_be("data_be_o", data_be_o, exp_be_q.pop_front());
            check_word("data_wdata_o", data_wdata_o, exp_data_q.pop_front());
            for (int i = 0; i < 4; i++)
              if (data_be_o[i])
                dmem[data_addr_o[9:2]][i*8 +: 8] = data_wdata_o[i*8 +: 8];
          end else begin
            if (!seen_store)
              stop_with("a load strobe appeared before the first store");
            data_rdata_i = dmem[data_addr_o[9:2]]; // Valid through the next cycle
          end
        end
      end
    end
  end

  initial begin
    wait (prog_len > 0);
    #((prog_len * 3 + 200) * CLK_PERIOD);
    stop_with("timeout: the program did not reach its end in time");
  end

  initial begin
    rst_n_i      = 1'b1;
    int_i        = 1'b0;
    mcause_i     = 32'h0;
    data_rdata_i = 32'h0;
    mem_cnt      = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i]   = enc_i(12'(i * 4), 5'd0, 3'b000, 5'd0, OPC_OP_IMM);
      dmem[i]   = (i * 32'h9E37_79B9) ^ 32'h5A5A_5A5A;
      shadow[i] = dmem[i];
    end
    build_program();
    if (end_pc >= HANDLER)
      stop_with("program does not fit below the trap handler");
    repeat (3) @(negedge clk_i);
    rst_n_i = 1'b0;
    check_addr("instr_addr_o", instr_addr_o, 32'h0);
    wait_pc(int_pc);
    int_i    = 1'b1;
    mcause_i = int_cause;
    #1;
    if (int_rst_o !== 1'b1)
      stop_with("int_rst_o did not acknowledge the interrupt");
    @(negedge clk_i);
    int_i = 1'b0;
    check_addr("instr_addr_o", instr_addr_o, HANDLER);
    check_word("mie_o", mie_o, MIE_VALUE);
    wait_pc(end_pc);
    repeat (3) @(negedge clk_i);
    if (exp_addr_q.size() != 0)
      stop_with($sformatf("store to %h never appeared", exp_addr_q[0]));
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: miriscv_core_assertions.sv
`timescale 1ns/1ps

module miriscv_core_assertions (
  input logic       clk_i,
  input logic       rst_n_i,
  input logic       data_req_o,
  input logic [3:0] data_be_o,
  input logic       int_rst_o
);

  // A request strobe lasts exactly one cycle
  req_single: assert property (@(posedge clk_i) disable iff (rst_n_i)
    data_req_o |=> !data_req_o)
    else $error("data_req_o was high for two cycles");

  be_nonzero: assert property (@(posedge clk_i) disable iff (rst_n_i)
    data_req_o |-> data_be_o != 4'b0000)
    else $error("data_be_o is zero during a request");

  int_single: assert property (@(posedge clk_i) disable iff (rst_n_i)
    int_rst_o |=> !int_rst_o)
    else $error("int_rst_o was high for two cycles");

  reset_quiet: assert property (@(posedge clk_i)
    rst_n_i |-> !data_req_o && !int_rst_o)
    else $error("bus or interrupt acknowledge active during reset");

endmodule

bind miriscv_core miriscv_core_assertions i_assertions (.*);

// File: miriscv_core.sv
`timescale 1ns/1ps

module miriscv_core import miriscv_pkg::*; #(
  parameter logic [31:0] BOOT_ADDR = 32'h0000_0000
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [31:0] instr_rdata_i,
  output logic [31:0] instr_addr_o,
  input  logic [31:0] data_rdata_i,
  output logic        data_req_o,
  output logic        data_we_o,
  output logic [3:0]  data_be_o,
  output logic [31:0] data_addr_o,
  output logic [31:0] data_wdata_o,
  input  logic        int_i,
  input  logic [31:0] mcause_i,
  output logic        int_rst_o,
  output logic [31:0] mie_o
);

  logic [31:0] instr;
  logic [31:0] pc_q;
  logic [31:0] imm_i, imm_s, imm_b, imm_j, imm_u;
  logic [31:0] rd1, rd2;
  logic [31:0] op_a, op_b;
  logic [31:0] alu_result;
  logic        alu_flag;
  logic [31:0] lsu_rdata;
  logic [31:0] csr_rdata;
  logic [31:0] wb_data;
  logic [31:0] mtvec, mepc;
  logic [31:0] pc_offset;
  op_a_sel_e   op_a_sel;
  op_b_sel_e   op_b_sel;
  alu_op_e     alu_op;
  mem_size_e   mem_size;
  pc_sel_e     pc_sel;
  csr_op_e     csr_op;
  logic        mem_req, mem_we, gpr_we, wb_src_sel, csr_sel;
  logic        branch, jal, enpc, lsu_stall;

  assign instr        = instr_rdata_i;
  assign instr_addr_o = pc_q;

  assign imm_i = {{21{instr[31]}}, instr[30:20]};
  assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  miriscv_decoder i_decoder (
    .fetched_instr_i(instr),
    .lsu_stall_req_i(lsu_stall),
    .int_i          (int_i),
    .ex_op_a_sel_o  (op_a_sel),
    .ex_op_b_sel_o  (op_b_sel),
    .alu_op_o       (alu_op),
    .mem_req_o      (mem_req),
    .mem_we_o       (mem_we),
    .mem_size_o     (mem_size),
    .gpr_we_a_o     (gpr_we),
    .wb_src_sel_o   (wb_src_sel),
    .csr_sel_o      (csr_sel),
    .csr_op_o       (csr_op),
    .branch_o       (branch),
    .jal_o          (jal),
    .pc_sel_o       (pc_sel),
    .enpc_o         (enpc),
    .illegal_instr_o(),
    .int_rst_o      (int_rst_o)
  );

  miriscv_rf i_rf (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .a1_i   (instr[19:15]),
    .a2_i   (instr[24:20]),
    .wa3_i  (instr[11:7]),
    .wd3_i  (wb_data),
    .we3_i  (gpr_we),
    .rd1_o  (rd1),
    .rd2_o  (rd2)
  );

  always_comb begin
    case (op_a_sel)
      OP_A_RS1:     op_a = rd1;
      OP_A_CURR_PC: op_a = pc_q;
      default:      op_a = '0;
    endcase
  end

  always_comb begin
    case (op_b_sel)
      OP_B_RS2:   op_b = rd2;
      OP_B_IMM_I: op_b = imm_i;
      OP_B_IMM_U: op_b = imm_u;
      OP_B_IMM_S: op_b = imm_s;
      OP_B_INCR:  op_b = 32'd4;
      default:    op_b = '0;
    endcase
  end

  miriscv_alu i_alu (
    .alu_op_i(alu_op),
    .a_i     (op_a),
    .b_i     (op_b),
    .result_o(alu_result),
    .flag_o  (alu_flag)
  );

  miriscv_csr i_csr (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .op_i    (csr_op),
    .addr_i  (instr[31:20]),
    .wd_i    (rd1),
    .pc_i    (pc_q),
    .mcause_i(mcause_i),
    .rd_o    (csr_rdata),
    .mie_o   (mie_o),
    .mtvec_o (mtvec),
    .mepc_o  (mepc)
  );

  miriscv_lsu i_lsu (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .lsu_addr_i     (alu_result),
    .lsu_we_i       (mem_we),
    .lsu_size_i     (mem_size),
    .lsu_data_i     (rd2),
    .lsu_req_i      (mem_req),
    .lsu_stall_req_o(lsu_stall),
    .lsu_data_o     (lsu_rdata),
    .data_rdata_i   (data_rdata_i),
    .data_req_o     (data_req_o),
    .data_we_o      (data_we_o),
    .data_be_o      (data_be_o),
    .data_addr_o    (data_addr_o),
    .data_wdata_o   (data_wdata_o)
  );

  assign wb_data = csr_sel ? csr_rdata : (wb_src_sel ? lsu_rdata : alu_result);

  // Taken branches use the B offset, JAL the J offset, all else steps by one word
  assign pc_offset = (branch && alu_flag) ? imm_b : (jal ? imm_j : 32'd4);

  always_ff @(posedge clk_i or posedge rst_n_i) begin
    if (rst_n_i) begin
      pc_q <= BOOT_ADDR;
    end else if (enpc) begin
      case (pc_sel)
        PC_NEXT:  pc_q <= pc_q + pc_offset;
        PC_JALR:  pc_q <= (rd1 + imm_i) & ~32'd1;
        PC_MEPC:  pc_q <= mepc;
        PC_MTVEC: pc_q <= mtvec;
        default:  pc_q <= pc_q + 32'd4;
      endcase
    end
  end

endmodule

// File: miriscv_lsu.sv
`timescale 1ns/1ps

module miriscv_lsu import miriscv_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [31:0] lsu_addr_i,
  input  logic        lsu_we_i,
  input  mem_size_e   lsu_size_i,
  input  logic [31:0] lsu_data_i,
  input  logic        lsu_req_i,
  output logic        lsu_stall_req_o,
  output logic [31:0] lsu_data_o,
  input  logic [31:0] data_rdata_i,
  output logic        data_req_o,
  output logic        data_we_o,
  output logic [3:0]  data_be_o,
  output logic [31:0] data_addr_o,
  output logic [31:0] data_wdata_o
);

  logic        second_q;   // Set during the second cycle of an access
  logic        first_cycle;
  logic [31:0] rdata_shift;

  assign first_cycle = lsu_req_i & ~second_q;

  always_ff @(posedge clk_i or posedge rst_n_i) begin
    if (rst_n_i)
      second_q <= 1'b0;
    else
      second_q <= first_cycle;
  end

  assign lsu_stall_req_o = first_cycle;
  assign data_req_o      = first_cycle;
  assign data_we_o       = first_cycle & lsu_we_i;
  assign data_addr_o     = {lsu_addr_i[31:2], 2'b00};

  // Byte lanes and replicated store data
  always_comb begin
    case (lsu_size_i)
      MEM_BYTE,
      MEM_BYTE_U: begin
        data_be_o    = 4'b0001 << lsu_addr_i[1:0];
        data_wdata_o = {4{lsu_data_i[7:0]}};
      end
      MEM_HALF,
      MEM_HALF_U: begin
        data_be_o    = lsu_addr_i[1] ? 4'b1100 : 4'b0011;
        data_wdata_o = {2{lsu_data_i[15:0]}};
      end
      default: begin
        data_be_o    = 4'b1111;
        data_wdata_o = lsu_data_i;
      end
    endcase
  end

  // Read data is valid in the second cycle, the addressed lane is moved down to bit 0
  assign rdata_shift = data_rdata_i >> {lsu_addr_i[1:0], 3'b000};

  always_comb begin
    case (lsu_size_i)
      MEM_BYTE:   lsu_data_o = {{24{rdata_shift[7]}}, rdata_shift[7:0]};
      MEM_BYTE_U: lsu_data_o = {24'b0, rdata_shift[7:0]};
      MEM_HALF:   lsu_data_o = {{16{rdata_shift[15]}}, rdata_shift[15:0]};
      MEM_HALF_U: lsu_data_o = {16'b0, rdata_shift[15:0]};
      default:    lsu_data_o = data_rdata_i;
    endcase
  end

endmodule

// File: miriscv_csr.sv
`timescale 1ns/1ps

module miriscv_csr import miriscv_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  csr_op_e     op_i,
  input  logic [11:0] addr_i,
  input  logic [31:0] wd_i,     // rs1 value
  input  logic [31:0] pc_i,
  input  logic [31:0] mcause_i,
  output logic [31:0] rd_o,
  output logic [31:0] mie_o,
  output logic [31:0] mtvec_o,
  output logic [31:0] mepc_o
);

  logic [31:0] mie_q;
  logic [31:0] mtvec_q;
  logic [31:0] mepc_q;
  logic [31:0] mcause_q;
  logic [31:0] new_val;

  // Old value of the addressed register, unknown addresses read zero
  always_comb begin
    case (addr_i)
      CSR_MIE:    rd_o = mie_q;
      CSR_MTVEC:  rd_o = mtvec_q;
      CSR_MEPC:   rd_o = mepc_q;
      CSR_MCAUSE: rd_o = mcause_q;
      default:    rd_o = '0;
    endcase
  end

  always_comb begin
    case (op_i)
      CSR_RW:  new_val = wd_i;
      CSR_RS:  new_val = rd_o | wd_i;
      CSR_RC:  new_val = rd_o & ~wd_i;
      default: new_val = rd_o;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_n_i) begin
    if (rst_n_i) begin
      mie_q    <= '0;
      mtvec_q  <= '0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      case (op_i)
        CSR_RW,
        CSR_RS,
        CSR_RC: begin
          case (addr_i)
            CSR_MIE:    mie_q    <= new_val;
            CSR_MTVEC:  mtvec_q  <= new_val;
            CSR_MEPC:   mepc_q   <= new_val;
            CSR_MCAUSE: mcause_q <= new_val;
            default:    ;
          endcase
        end
        CSR_INT: begin
          mepc_q   <= pc_i; // Interrupted instruction is re-run after MRET
          mcause_q <= mcause_i;
        end
        default: ; // MRET only reads mepc through mepc_o
      endcase
    end
  end

  assign mie_o   = mie_q;
  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

endmodule

// File: miriscv_rf.sv
`timescale 1ns/1ps

module miriscv_rf (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [4:0]  a1_i,
  input  logic [4:0]  a2_i,
  input  logic [4:0]  wa3_i,
  input  logic [31:0] wd3_i,
  input  logic        we3_i,
  output logic [31:0] rd1_o,
  output logic [31:0] rd2_o
);

  logic [31:0] regs_q [32];

  always_ff @(posedge clk_i or posedge rst_n_i) begin
    if (rst_n_i) begin
      for (int i = 0; i < 32; i++)
        regs_q[i] <= '0;
    end else if (we3_i && wa3_i != 5'd0) begin
      regs_q[wa3_i] <= wd3_i; // Writes to x0 are dropped
    end
  end

  assign rd1_o = (a1_i == 5'd0) ? 32'd0 : regs_q[a1_i];
  assign rd2_o = (a2_i == 5'd0) ? 32'd0 : regs_q[a2_i];

endmodule

// File: miriscv_decoder.sv
`timescale 1ns/1ps

module miriscv_decoder import miriscv_pkg::*; (
  input  logic [31:0] fetched_instr_i,
  input  logic        lsu_stall_req_i,
  input  logic        int_i,
  output op_a_sel_e   ex_op_a_sel_o,
  output op_b_sel_e   ex_op_b_sel_o,
  output alu_op_e     alu_op_o,
  output logic        mem_req_o,
  output logic        mem_we_o,
  output mem_size_e   mem_size_o,
  output logic        gpr_we_a_o,
  output logic        wb_src_sel_o, // 1 selects the load data
  output logic        csr_sel_o,    // 1 selects the old CSR value
  output csr_op_e     csr_op_o,
  output logic        branch_o,
  output logic        jal_o,
  output pc_sel_e     pc_sel_o,
  output logic        enpc_o,
  output logic        illegal_instr_o,
  output logic        int_rst_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = opcode_e'(fetched_instr_i[6:0]);
  assign funct3 = fetched_instr_i[14:12];
  assign funct7 = fetched_instr_i[31:25];

  // The interrupt waits until no memory access is in flight, so a store is never replayed
  assign int_rst_o = int_i & ~lsu_stall_req_i & ~mem_req_o;

  // Memory controls depend on the instruction alone since the LSU stall is derived from them
  always_comb begin
    mem_req_o  = 1'b0;
    mem_we_o   = 1'b0;
    mem_size_o = MEM_WORD;
    if (opcode == OPC_LOAD && funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
      mem_req_o  = 1'b1;
      mem_size_o = mem_size_e'(funct3);
    end else if (opcode == OPC_STORE && funct3 < 3'b011) begin
      mem_req_o  = 1'b1;
      mem_we_o   = 1'b1;
      mem_size_o = mem_size_e'(funct3);
    end
  end

  always_comb begin
    ex_op_a_sel_o   = OP_A_RS1;
    ex_op_b_sel_o   = OP_B_RS2;
    alu_op_o        = ALU_ADD;
    gpr_we_a_o      = 1'b0;
    wb_src_sel_o    = 1'b0;
    csr_sel_o       = 1'b0;
    csr_op_o        = CSR_NONE;
    branch_o        = 1'b0;
    jal_o           = 1'b0;
    pc_sel_o        = PC_NEXT;
    illegal_instr_o = 1'b0;

    case (opcode)
      OPC_OP: begin
        gpr_we_a_o = 1'b1;
        alu_op_o   = alu_op_e'({1'b0, funct7[5], funct3});
        if (funct7 == 7'b0100000)
          illegal_instr_o = (funct3 != 3'b000) && (funct3 != 3'b101);
        else
          illegal_instr_o = (funct7 != 7'b0000000);
      end
      OPC_OP_IMM: begin
        gpr_we_a_o    = 1'b1;
        ex_op_b_sel_o = OP_B_IMM_I;
        if (funct3 == 3'b101) begin // SRLI and SRAI share funct3
          alu_op_o        = alu_op_e'({1'b0, funct7[5], funct3});
          illegal_instr_o = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
        end else begin
          alu_op_o        = alu_op_e'({2'b00, funct3});
          illegal_instr_o = (funct3 == 3'b001) && (funct7 != 7'b0000000);
        end
      end
      OPC_LUI: begin
        gpr_we_a_o    = 1'b1;
        ex_op_a_sel_o = OP_A_ZERO;
        ex_op_b_sel_o = OP_B_IMM_U;
      end
      OPC_AUIPC: begin
        gpr_we_a_o    = 1'b1;
        ex_op_a_sel_o = OP_A_CURR_PC;
        ex_op_b_sel_o = OP_B_IMM_U;
      end
      OPC_JAL: begin
        gpr_we_a_o    = 1'b1; // Link register gets PC + 4
        ex_op_a_sel_o = OP_A_CURR_PC;
        ex_op_b_sel_o = OP_B_INCR;
        jal_o         = 1'b1;
      end
      OPC_JALR: begin
        gpr_we_a_o      = 1'b1;
        ex_op_a_sel_o   = OP_A_CURR_PC;
        ex_op_b_sel_o   = OP_B_INCR;
        pc_sel_o        = PC_JALR;
        illegal_instr_o = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        branch_o        = 1'b1;
        alu_op_o        = alu_op_e'({2'b11, funct3});
        illegal_instr_o = (funct3[2:1] == 2'b01);
      end
      OPC_LOAD: begin
        gpr_we_a_o      = 1'b1;
        wb_src_sel_o    = 1'b1;
        ex_op_b_sel_o   = OP_B_IMM_I;
        illegal_instr_o = ~mem_req_o;
      end
      OPC_STORE: begin
        ex_op_b_sel_o   = OP_B_IMM_S;
        illegal_instr_o = ~mem_req_o;
      end
      OPC_SYSTEM: begin
        case (funct3)
          3'b000: begin
            if (fetched_instr_i == 32'h3020_0073) begin // MRET
              csr_op_o = CSR_MRET;
              pc_sel_o = PC_MEPC;
            end else begin
              illegal_instr_o = 1'b1;
            end
          end
          3'b001,
          3'b010,
          3'b011: begin
            gpr_we_a_o = 1'b1;
            csr_sel_o  = 1'b1;
            csr_op_o   = csr_op_e'({1'b0, funct3[1:0]}); // RW, RS, RC in funct3 order
          end
          default: illegal_instr_o = 1'b1;
        endcase
      end
      default: illegal_instr_o = 1'b1;
    endcase

    // An unknown encoding behaves as a NOP
    if (illegal_instr_o) begin
      gpr_we_a_o = 1'b0;
      csr_op_o   = CSR_NONE;
      branch_o   = 1'b0;
      jal_o      = 1'b0;
      pc_sel_o   = PC_NEXT;
    end

    if (lsu_stall_req_i) begin
      gpr_we_a_o = 1'b0;
      csr_op_o   = CSR_NONE;
    end
    enpc_o = ~lsu_stall_req_i;

    // Trap entry replaces whatever the current instruction would do
    if (int_rst_o) begin
      gpr_we_a_o = 1'b0;
      csr_sel_o  = 1'b0;
      csr_op_o   = CSR_INT;
      branch_o   = 1'b0;
      jal_o      = 1'b0;
      pc_sel_o   = PC_MTVEC;
      enpc_o     = 1'b1;
    end
  end

endmodule

// File: miriscv_alu.sv
`timescale 1ns/1ps

module miriscv_alu import miriscv_pkg::*; (
  input  alu_op_e     alu_op_i,
  input  logic [31:0] a_i,
  input  logic [31:0] b_i,
  output logic [31:0] result_o,
  output logic        flag_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0]; // Only the low five bits count for shifts

  always_comb begin
    result_o = '0;
    flag_o   = 1'b0;
    case (alu_op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SLT:  result_o = {31'b0, $signed(a_i) < $signed(b_i)};
      ALU_SLTU: result_o = {31'b0, a_i < b_i};
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = $signed(a_i) >>> shamt;
      ALU_OR:   result_o = a_i | b_i;
      ALU_AND:  result_o = a_i & b_i;
      // Branch compares leave the result at zero
      ALU_EQ:   flag_o = (a_i == b_i);
      ALU_NE:   flag_o = (a_i != b_i);
      ALU_LT:   flag_o = $signed(a_i) < $signed(b_i);
      ALU_GE:   flag_o = $signed(a_i) >= $signed(b_i);
      ALU_LTU:  flag_o = a_i < b_i;
      ALU_GEU:  flag_o = a_i >= b_i;
      default: begin
        result_o = '0;
        flag_o   = 1'b0;
      end
    endcase
  end

endmodule

// File: miriscv_pkg.sv
package miriscv_pkg;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // Arithmetic codes follow {funct7[5], funct3}, compares follow {2'b11, funct3}
  typedef enum logic [4:0] {
    ALU_ADD  = 5'b00000,
    ALU_SLL  = 5'b00001,
    ALU_SLT  = 5'b00010,
    ALU_SLTU = 5'b00011,
    ALU_XOR  = 5'b00100,
    ALU_SRL  = 5'b00101,
    ALU_OR   = 5'b00110,
    ALU_AND  = 5'b00111,
    ALU_SUB  = 5'b01000,
    ALU_SRA  = 5'b01101,
    ALU_EQ   = 5'b11000,
    ALU_NE   = 5'b11001,
    ALU_LT   = 5'b11100,
    ALU_GE   = 5'b11101,
    ALU_LTU  = 5'b11110,
    ALU_GEU  = 5'b11111
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_RS1     = 2'd0,
    OP_A_CURR_PC = 2'd1,
    OP_A_ZERO    = 2'd2
  } op_a_sel_e;

  typedef enum logic [2:0] {
    OP_B_RS2   = 3'd0,
    OP_B_IMM_I = 3'd1,
    OP_B_IMM_U = 3'd2,
    OP_B_IMM_S = 3'd3,
    OP_B_INCR  = 3'd4 // Constant 4 for link addresses
  } op_b_sel_e;

  // Same values as funct3 of loads and stores
  typedef enum logic [2:0] {
    MEM_BYTE   = 3'b000,
    MEM_HALF   = 3'b001,
    MEM_WORD   = 3'b010,
    MEM_BYTE_U = 3'b100,
    MEM_HALF_U = 3'b101
  } mem_size_e;

  typedef enum logic [1:0] {
    PC_NEXT  = 2'd0, // PC plus 4 or the branch/jump offset
    PC_JALR  = 2'd1,
    PC_MEPC  = 2'd2,
    PC_MTVEC = 2'd3
  } pc_sel_e;

  typedef enum logic [2:0] {
    CSR_NONE = 3'd0,
    CSR_RW   = 3'd1,
    CSR_RS   = 3'd2,
    CSR_RC   = 3'd3,
    CSR_INT  = 3'd4,
    CSR_MRET = 3'd5
  } csr_op_e;

  localparam logic [11:0] CSR_MIE    = 12'h304;
  localparam logic [11:0] CSR_MTVEC  = 12'h305;
  localparam logic [11:0] CSR_MEPC   = 12'h341;
  localparam logic [11:0] CSR_MCAUSE = 12'h342;

endpackage
